// File: flist.f
design/knight_cmd_pkg.sv
design/knight_motion_pkg.sv
design/move_if.sv
design/ramp_if.sv
design/heading_err.sv
design/square_counter.sv
design/speed_ramp.sv
design/cmd_sequencer.sv
design/cmd_proc_top.sv
bench/tb_cmd_proc.sv

// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing
TOP   = tb_cmd_proc
FLIST = flist.f
LOG   = sim.log
PASS  = No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FLIST)

obj_dir/V$(TOP): $(FLIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS)$$" $(LOG) && echo "Simulation passed" || \
	  (echo "Simulation failed"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: bench/tb_cmd_proc.sv
// Command processor testbench with clock, robot model, reference model, checks and report.
`timescale 1ns/1ps

module tb_cmd_proc;
  import knight_cmd_pkg::*;
  import knight_motion_pkg::*;

  localparam int move_max  = 420;                   // Longest move with 15 squares and a full ramp.
  localparam int cyc_limit = 120 + 4 * move_max + 300;

  logic clk, rst_n, cmd_rdy, cal_done, heading_rdy, lft_ir, cntr_ir, rght_ir;
  logic [cmd_w-1:0] cmd;
  logic signed [hdg_w-1:0] heading;
  logic clr_cmd_rdy, send_resp, strt_cal, moving, tour_go, fanfare_go;
  logic signed [hdg_w-1:0] error;
  logic [spd_w-1:0] frwrd;

  int cycles, errors, tests, resp_cnt, fan_cnt, clr_cnt, edges, cur_sq, hr_div, robot_div;
  logic [31:0] rng;
  bit mon_en, turning, went_down, cntr_prev, hr_prev, up_ok, dn_ok;
  logic [spd_w-1:0] f_prev;

  cmd_proc_top u_cmd_proc_top (
    .clk(clk), .rst_n(rst_n), .cmd(cmd), .cmd_rdy(cmd_rdy), .clr_cmd_rdy(clr_cmd_rdy),
    .send_resp(send_resp), .strt_cal(strt_cal), .cal_done(cal_done), .heading(heading),
    .heading_rdy(heading_rdy), .lft_ir(lft_ir), .cntr_ir(cntr_ir), .rght_ir(rght_ir),
    .error(error), .frwrd(frwrd), .moving(moving), .tour_go(tour_go), .fanfare_go(fanfare_go)
  );

  always #5 clk = ~clk;                             // 10 ns period.

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  function automatic logic [31:0] next_rand();
    rng = rng * 32'd1664525 + 32'd1013904223;
    return rng;
  endfunction

  function automatic logic signed [hdg_w-1:0] desired_heading(input logic [7:0] code);
    return (code == 8'h00) ? 12'sd0 : {code, 4'hF};  // Code times 16 with the low nibble filled.
  endfunction

  function automatic logic signed [hdg_w-1:0] expected_error(input logic signed [hdg_w-1:0] h,
      input logic signed [hdg_w-1:0] des, input logic l, input logic r);
    logic signed [hdg_w-1:0] n;
    n = l ? nudge_lft : (r ? nudge_rght : 12'sd0);
    return h - des + n;
  endfunction

  function automatic logic [spd_w-1:0] frwrd_after_step(input logic [spd_w-1:0] f,
      input bit up);
    if (up) return (f >= 10'h300) ? f : f + spd_w'(inc_step);  // Saturates at 0x300.
    return (f < spd_w'(dec_step)) ? '0 : f - spd_w'(dec_step);
  endfunction

  function automatic int edges_for_squares(input int sq);
    return 2 * sq;                                  // Two tape edges per square.
  endfunction

  task automatic fail(input string msg);
    $display("[FAIL] t=%0t ns %s", $time, msg);
    errors++;
  endtask

  task automatic report(input string name, input int e0);
    tests++;
    if (errors == e0) $display("Test %s: passed", name);
    else $display("Test %s: %0d errors", name, errors - e0);
  endtask

  ////////////////////////////////////////
  // Gyro strobe, robot and timeout
  ////////////////////////////////////////
  always @(posedge clk) begin
    hr_div      <= (hr_div + 1) % 8;
    heading_rdy <= (hr_div == 7);                   // One strobe every 8 cycles.
    if (frwrd != '0) begin                          // Lines pass while the wheels turn.
      robot_div <= (robot_div + 1) % 4;
      if (robot_div == 3) cntr_ir <= ~cntr_ir;
    end
    cycles <= cycles + 1;
    if (cycles >= cyc_limit) begin
      $display("Timeout: the run passed %0d cycles without finishing", cyc_limit);
      $display("Errors found");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Checker sampled at the falling edge
  ////////////////////////////////////////
  always @(negedge clk) begin
    resp_cnt += int'(send_resp);
    fan_cnt  += int'(fanfare_go);
    clr_cnt  += int'(clr_cmd_rdy);
    if (mon_en) begin
      if (cntr_ir && !cntr_prev) edges++;
      if (turning) begin
        if (frwrd != '0) fail($sformatf("frwrd %h while not aligned", frwrd));
      end else if (!hr_prev) begin
        if (frwrd != f_prev)
          fail($sformatf("frwrd changed between strobes %h -> %h", f_prev, frwrd));
      end else begin
        // Every strobe must step, up before the last crossing, down after it.
        up_ok = frwrd == frwrd_after_step(f_prev, 1'b1) && !went_down &&
                edges <= edges_for_squares(cur_sq);
        dn_ok = frwrd == frwrd_after_step(f_prev, 1'b0) &&
                edges >= edges_for_squares(cur_sq);
        if (dn_ok)
          went_down = 1;
        else if (!up_ok)
          fail($sformatf("frwrd step %h -> %h, edges %0d", f_prev, frwrd, edges));
      end
    end else begin
      went_down = 0;
    end
    cntr_prev = cntr_ir;
    f_prev    = frwrd;
    hr_prev   = heading_rdy;
  end

  ////////////////////////////////////////
  // Host side tasks
  ////////////////////////////////////////
  // Raise cmd_rdy and return at the falling edge of the accepting cycle.
  task automatic send_cmd(input logic [cmd_w-1:0] word, output int waited);
    @(posedge clk);
    cmd     <= word;
    cmd_rdy <= 1'b1;
    waited  = 0;
    @(negedge clk);
    while (!clr_cmd_rdy) begin
      waited++;
      @(negedge clk);
    end
  endtask

  task automatic tour_test();
    int e0, w;
    e0 = errors;
    send_cmd({op_tour, 12'h000}, w);
    if (w != 0 || !tour_go) fail("tour_go not with the accepting clr_cmd_rdy");
    if (send_resp || strt_cal || moving) fail("unexpected output during TOUR");
    @(posedge clk) cmd_rdy <= 1'b0;
    repeat (4) begin
      @(negedge clk);
      if (send_resp || moving || tour_go) fail("activity after TOUR");
    end
    report("tour", e0);
  endtask

  task automatic cal_test();
    int e0, w, dly;
    e0  = errors;
    dly = 3 + next_rand() % 18;
    send_cmd({op_cal, 12'h000}, w);
    if (w != 0 || !strt_cal) fail("strt_cal not with the accepting clr_cmd_rdy");
    @(posedge clk) cmd_rdy <= 1'b0;
    repeat (dly) begin
      @(negedge clk);
      if (send_resp || moving || strt_cal) fail("early activity during CAL");
    end
    @(posedge clk) cal_done <= 1'b1;
    @(negedge clk);
    if (!send_resp || moving) fail("send_resp missing or moving high in the cal_done cycle");
    @(posedge clk) cal_done <= 1'b0;
    @(negedge clk);
    if (send_resp || moving) fail("send_resp or moving after CAL");
    report("cal", e0);
  endtask

  task automatic move_test(input string name, input logic [3:0] op, input int sq,
      input bit queue);
    int e0, w, resp0, fan0, clr0;
    logic [7:0] code;
    logic signed [hdg_w-1:0] des, h, exp_err;
    logic l, r;
    e0 = errors;
    code = 8'(next_rand() >> 8);
    des = desired_heading(code);
    resp0 = resp_cnt;
    fan0 = fan_cnt;
    @(posedge clk);
    heading <= des + 12'sh400;                      // Far off until the turn is done.
    lft_ir  <= 1'b0;
    rght_ir <= 1'b0;
    cur_sq  = sq;
    edges   = 0;
    turning = 1;
    mon_en  = 1;
    send_cmd({op, code, 4'(sq)}, w);
    @(posedge clk) cmd_rdy <= 1'b0;
    repeat (6) begin                                // Random error samples while turning.
      h = hdg_w'(next_rand() >> 12);
      l = 1'(next_rand() >> 20);
      r = 1'(next_rand() >> 24);
      exp_err = expected_error(h, des, l, r);
      if (exp_err < 12'sh030 && exp_err > -12'sh030) h = h + 12'sh200;
      exp_err = expected_error(h, des, l, r);
      @(posedge clk);
      heading <= h;
      lft_ir  <= l;
      rght_ir <= r;
      @(negedge clk);
      if (error !== exp_err) fail($sformatf("error %h, expected %h", error, exp_err));
      if (!moving || frwrd != '0) fail("not turning in place");
    end
    @(posedge clk);
    heading <= des;                                 // Point the right way.
    lft_ir  <= 1'b0;
    rght_ir <= 1'b0;
    if (queue) begin
      cmd     <= {op_tour, 12'h000};                // Held off until the response.
      cmd_rdy <= 1'b1;
    end
    clr0 = clr_cnt;
    repeat (2) @(posedge clk);                      // Aligned, then the FSM leaves the turn.
    turning = 0;
    do @(negedge clk); while (!send_resp);
    if (frwrd != '0) fail("send_resp before frwrd reached 0");
    if (edges < edges_for_squares(sq)) fail($sformatf("response after %0d edges", edges));
    if (clr_cnt != clr0 || clr_cmd_rdy) fail("second command accepted during the move");
    mon_en = 0;
    @(negedge clk);
    if (moving) fail("moving high after the response");
    if (queue && !(clr_cmd_rdy && tour_go)) fail("queued command not taken after response");
    @(posedge clk) cmd_rdy <= 1'b0;
    @(posedge clk);
    if (resp_cnt - resp0 != 1) fail("send_resp count not one");
    if (fan_cnt - fan0 != int'(op == op_fanfare)) fail("wrong fanfare_go count");
    report(name, e0);
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////
  initial begin
    clk = 0;
    rst_n = 0;
    cmd = '0;
    cmd_rdy = 0;
    cal_done = 0;
    heading = '0;
    heading_rdy = 0;
    lft_ir = 0;
    cntr_ir = 0;
    rght_ir = 0;
    rng = 32'hc18d_fa81;
    {cycles, errors, tests, resp_cnt, fan_cnt, clr_cnt, edges, hr_div, robot_div} = '0;
    {mon_en, turning, went_down, cntr_prev, hr_prev, up_ok, dn_ok} = '0;
    f_prev = '0;
    cur_sq = 0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (clr_cmd_rdy || send_resp || strt_cal || tour_go || fanfare_go || moving || frwrd != 0)
      fail("outputs not idle after reset");
    tour_test();
    cal_test();
    move_test("mov_short", op_mov, 1 + next_rand() % 4, 1'b0);
    move_test("mov_full_speed", op_mov, 15, 1'b0);
    move_test("fanfare", op_fanfare, 1 + next_rand() % 6, 1'b1);
    move_test("fanfare_again", op_fanfare, 2, 1'b0);
    $display("Summary: %0d tests, %0d errors", tests, errors);
    if (errors == 0) $display("No errors");
    else $display("Errors found");
    $finish;
  end

endmodule

// File: design/cmd_proc_top.sv
// Command processor top level joining heading, square count, speed ramp and FSM.
`timescale 1ns/1ps

module cmd_proc_top (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic [knight_cmd_pkg::cmd_w-1:0]          cmd,
  input  logic                                      cmd_rdy,
  output logic                                      clr_cmd_rdy,
  output logic                                      send_resp,
  output logic                                      strt_cal,
  input  logic                                      cal_done,
  input  logic signed [knight_motion_pkg::hdg_w-1:0] heading,
  input  logic                                      heading_rdy,
  input  logic                                      lft_ir,
  input  logic                                      cntr_ir,
  input  logic                                      rght_ir,
  output logic signed [knight_motion_pkg::hdg_w-1:0] error,
  output logic [knight_motion_pkg::spd_w-1:0]       frwrd,
  output logic                                      moving,
  output logic                                      tour_go,
  output logic                                      fanfare_go
);

  ////////////////////////////////////////
  // Internal buses
  ////////////////////////////////////////
  move_if u_move_if ();   // Move setup and status.
  ramp_if u_ramp_if ();   // Speed ramp control.

  ////////////////////////////////////////
  // Datapath units
  ////////////////////////////////////////
  heading_err u_heading_err (
    .clk     (clk),
    .rst_n   (rst_n),
    .mv      (u_move_if.hdg),
    .heading (heading),
    .lft_ir  (lft_ir),
    .rght_ir (rght_ir),
    .error   (error)
  );

  square_counter u_square_counter (
    .clk     (clk),
    .rst_n   (rst_n),
    .mv      (u_move_if.sq),
    .cntr_ir (cntr_ir)
  );

  speed_ramp u_speed_ramp (
    .clk         (clk),
    .rst_n       (rst_n),
    .rp          (u_ramp_if.ramp),
    .heading_rdy (heading_rdy),
    .frwrd       (frwrd)
  );

  // Control.
  cmd_sequencer u_cmd_sequencer (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd         (cmd),
    .cmd_rdy     (cmd_rdy),
    .clr_cmd_rdy (clr_cmd_rdy),
    .cal_done    (cal_done),
    .strt_cal    (strt_cal),
    .send_resp   (send_resp),
    .tour_go     (tour_go),
    .fanfare_go  (fanfare_go),
    .moving      (moving),
    .mv          (u_move_if.seq),
    .rp          (u_ramp_if.seq)
  );

endmodule

// File: design/cmd_sequencer.sv
// Command FSM: accept, calibrate, turn, ramp up, count squares, ramp down, respond.
`timescale 1ns/1ps

module cmd_sequencer (
  input  logic                      clk,
  input  logic                      rst_n,
  input  knight_cmd_pkg::cmd_word_u cmd,
  input  logic                      cmd_rdy,
  output logic                      clr_cmd_rdy,
  input  logic                      cal_done,
  output logic                      strt_cal,
  output logic                      send_resp,
  output logic                      tour_go,
  output logic                      fanfare_go,
  output logic                      moving,
  move_if.seq                       mv,
  ramp_if.seq                       rp
);
  import knight_cmd_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_calibrate,
    st_turn,
    st_accel,
    st_decel
  } state_t;

  state_t          state;        // Present state.
  state_t          nxt_state;
  logic [op_w-1:0] opcode;       // Opcode of the word on the bus.
  logic            fanfare_cmd;  // Move in flight ends with the fanfare.

  assign opcode      = cmd.gen.opcode;     // Decoded through the generic view.
  assign mv.hdg_code = cmd.mv.hdg_code;    // Only sampled while load is high.
  assign mv.squares  = cmd.mv.squares;

  ////////////////////////////////////////
  // State and move flavour
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      state <= st_idle;
    else
      state <= nxt_state;
  end

  // The host may already present the next word, so keep our own copy.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      fanfare_cmd <= 1'b0;
    else if (mv.load)
      fanfare_cmd <= (opcode == op_fanfare);
  end

  ////////////////////////////////////////
  // Next state and outputs
  ////////////////////////////////////////
  always_comb begin
    nxt_state   = state;
    clr_cmd_rdy = 1'b0;
    strt_cal    = 1'b0;
    send_resp   = 1'b0;
    tour_go     = 1'b0;
    fanfare_go  = 1'b0;
    moving      = 1'b0;
    mv.load     = 1'b0;
    rp.clr      = 1'b0;
    rp.inc      = 1'b0;
    rp.dec      = 1'b0;

    case (state)
      st_calibrate: begin
        if (cal_done) begin
          send_resp = 1'b1;             // Report the first cycle of done.
          nxt_state = st_idle;
        end
      end

      st_turn: begin
        moving = 1'b1;                  // Spinning in place still counts.
        if (mv.aligned) begin
          rp.clr    = 1'b1;             // Ramp from standstill.
          nxt_state = st_accel;
        end
      end

      st_accel: begin
        moving = 1'b1;
        rp.inc = 1'b1;
        if (mv.move_done) begin
          fanfare_go = fanfare_cmd;     // Single pulse on the way out.
          nxt_state  = st_decel;
        end
      end

      st_decel: begin
        rp.dec = 1'b1;
        if (rp.zero) begin
          send_resp = 1'b1;             // Stopped, tell the host.
          nxt_state = st_idle;
        end else begin
          moving = 1'b1;
        end
      end

      default: begin                    // Idle, waiting on the host.
        if (cmd_rdy) begin
          clr_cmd_rdy = 1'b1;           // Consume whatever arrived.
          case (opcode)
            op_tour: tour_go = 1'b1;    // No response for a tour.
            op_cal: begin
              strt_cal  = 1'b1;
              nxt_state = st_calibrate;
            end
            op_mov, op_fanfare: begin
              mv.load   = 1'b1;         // Latch heading and squares.
              nxt_state = st_turn;
            end
            default: ;                  // Unknown opcode is dropped.
          endcase
        end
      end
    endcase
  end

endmodule

// File: design/speed_ramp.sv
// Forward speed register with saturating ramp up and clamped ramp down.
`timescale 1ns/1ps

module speed_ramp (
  input  logic                               clk,
  input  logic                               rst_n,
  ramp_if.ramp                               rp,
  input  logic                               heading_rdy,
  output logic [knight_motion_pkg::spd_w-1:0] frwrd
);
  import knight_motion_pkg::*;

  logic             at_max;   // Both top bits set.
  logic             low_spd;  // Less than one down step left.
  logic [spd_w-1:0] inc_amt;  // Step widened to the register.
  logic [spd_w-1:0] dec_amt;

  assign inc_amt = spd_w'(inc_step);
  assign dec_amt = spd_w'(dec_step);

  assign at_max  = &frwrd[spd_w-1:spd_w-2];  // Top speed reached.
  assign low_spd = (frwrd < dec_amt);        // Next step would underflow.
  assign rp.zero = (frwrd == '0);

  ////////////////////////////////////////
  // Speed register
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frwrd <= '0;
    end else if (rp.clr) begin
      frwrd <= '0;                           // Start of a new ramp.
    end else if (heading_rdy) begin          // Only step with fresh gyro data.
      if (rp.inc) begin
        if (!at_max)
          frwrd <= frwrd + inc_amt;          // Speed up.
      end else if (rp.dec) begin
        if (low_spd)
          frwrd <= '0;                       // Clamp, never wrap.
        else
          frwrd <= frwrd - dec_amt;          // Slow down.
      end
    end
  end

endmodule

// File: design/square_counter.sv
// Centre IR edge detector, line crossing counter and move-done compare.
`timescale 1ns/1ps

module square_counter (
  input  logic clk,
  input  logic rst_n,
  move_if.sq   mv,
  input  logic cntr_ir
);
  import knight_cmd_pkg::*;

  logic            cntr_ir_q;   // Last sample of the centre IR.
  logic            cntr_rise;   // Line just entered.
  logic [sq_w:0]   pulse_cnt;   // Crossings since the move began.
  logic [sq_w-1:0] square_cnt;  // Squares requested for this move.

  ////////////////////////////////////////
  // Edge detect
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      cntr_ir_q <= 1'b0;
    else
      cntr_ir_q <= cntr_ir;                   // One cycle of history.
  end

  assign cntr_rise = cntr_ir & ~cntr_ir_q;    // Low to high.

  ////////////////////////////////////////
  // Counters
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      square_cnt <= '0;
      pulse_cnt  <= '0;
    end else if (mv.load) begin
      square_cnt <= mv.squares;               // Capture the request.
      pulse_cnt  <= '0;                       // Fresh move.
    end else if (cntr_rise) begin
      pulse_cnt  <= pulse_cnt + 1'b1;         // One more line crossed.
    end
  end

  // Two crossings per square, one on each tape edge.
  assign mv.move_done = (pulse_cnt == {square_cnt, 1'b0});

endmodule

// File: design/heading_err.sv
// Desired heading register, IR nudge, heading error and alignment test.
`timescale 1ns/1ps

module heading_err (
  input  logic                                   clk,
  input  logic                                   rst_n,
  move_if.hdg                                    mv,
  input  logic signed [knight_motion_pkg::hdg_w-1:0] heading,
  input  logic                                   lft_ir,
  input  logic                                   rght_ir,
  output logic signed [knight_motion_pkg::hdg_w-1:0] error
);
  import knight_cmd_pkg::*;
  import knight_motion_pkg::*;

  logic signed [hdg_w-1:0] desired_hdg;  // Heading the robot should hold.
  logic signed [hdg_w-1:0] nudge;        // IR steering bias.
  logic        [hdg_w-1:0] err_abs;      // Magnitude of the error.

  ////////////////////////////////////////
  // Desired heading
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      desired_hdg <= '0;                           // Face north.
    end else if (mv.load) begin
      if (mv.hdg_code == '0)
        desired_hdg <= '0;                         // Zero code stays exact.
      else
        desired_hdg <= {mv.hdg_code, hdg_fill};    // Code scaled up, low bits filled.
    end
  end

  ////////////////////////////////////////
  // Error term
  ////////////////////////////////////////
  assign nudge = nudge_of(lft_ir, rght_ir);        // Left has priority.

  assign error = heading - desired_hdg + nudge;    // Fed to the PID.

  // Absolute value, most negative value reads as large.
  assign err_abs = error[hdg_w-1] ? hdg_w'(-error) : hdg_w'(error);

  assign mv.aligned = (err_abs < align_thresh);    // Close enough to drive off.

endmodule

// File: design/ramp_if.sv
// Speed ramp control bundle between the sequencer and the forward speed register.
`timescale 1ns/1ps

interface ramp_if;

  logic clr;   // Empty the speed register.
  logic inc;   // Ramp up on heading_rdy.
  logic dec;   // Ramp down on heading_rdy.
  logic zero;  // Speed register is empty.

  // Sequencer drives the commands.
  modport seq (
    output clr, inc, dec,
    input  zero
  );

  // Speed register side.
  modport ramp (
    input  clr, inc, dec,
    output zero
  );

endinterface

// File: design/move_if.sv
// Move control bundle between the sequencer, the heading unit and the square counter.
`timescale 1ns/1ps

interface move_if;
  import knight_cmd_pkg::*;

  logic                  load;       // One-cycle pulse, fields valid with it.
  logic [hdg_code_w-1:0] hdg_code;   // Heading code of the new move.
  logic [sq_w-1:0]       squares;    // Squares to travel.
  logic                  aligned;    // Heading within threshold.
  logic                  move_done;  // All line crossings seen.

  // Sequencer side.
  modport seq (
    output load, hdg_code, squares,
    input  aligned, move_done
  );

  // Heading error unit.
  modport hdg (
    input  load, hdg_code,
    output aligned
  );

  // Square counter.
  modport sq (
    input  load, squares,
    output move_done
  );

endinterface

// File: design/knight_motion_pkg.sv
// Heading and speed widths, ramp steps, IR nudge values and the alignment limit.
package knight_motion_pkg;

  ////////////////////////////////////////
  // Datapath widths
  ////////////////////////////////////////
  localparam int hdg_w  = 12;  // Heading, desired heading and error.
  localparam int spd_w  = 10;  // Forward speed register.
  localparam int step_w = 7;   // Ramp step size.

  ////////////////////////////////////////
  // Speed ramp
  ////////////////////////////////////////
  localparam logic [step_w-1:0] inc_step = 7'h20;  // Added per heading_rdy.
  localparam logic [step_w-1:0] dec_step = 7'h40;  // Removed per heading_rdy.

  ////////////////////////////////////////
  // Heading correction
  ////////////////////////////////////////
  // Left IR sees the line, steer back with a positive bias.
  localparam logic signed [hdg_w-1:0] nudge_lft  = 12'sh1FF;
  // Right IR sees the line, bias the other way.
  localparam logic signed [hdg_w-1:0] nudge_rght = 12'shE00;

  // |error| below this counts as pointed the right way.
  localparam logic [hdg_w-1:0] align_thresh = 12'h02C;

  // Low nibble appended to a nonzero heading code.
  localparam logic [3:0] hdg_fill = 4'hF;

  // Nudge choice, left IR wins over right.
  function automatic logic signed [hdg_w-1:0] nudge_of(input logic lft, input logic rght);
    logic signed [hdg_w-1:0] n;
    n = '0;                           // Centred, no bias.
    if (lft)       n = nudge_lft;
    else if (rght) n = nudge_rght;
    return n;
  endfunction

endpackage

// File: design/knight_cmd_pkg.sv
// Command word layout, opcode values and the two-view command word union.
package knight_cmd_pkg;

  ////////////////////////////////////////
  // Field widths
  ////////////////////////////////////////
  localparam int cmd_w      = 16;  // Full command word from the Bluetooth link.
  localparam int op_w       = 4;   // Opcode in the top nibble.
  localparam int hdg_code_w = 8;   // Coarse heading code of a move.
  localparam int sq_w       = 4;   // Number of squares to travel.

  ////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////
  localparam logic [op_w-1:0] op_cal     = 4'h2;  // Gyro calibration.
  localparam logic [op_w-1:0] op_mov     = 4'h4;  // Plain move.
  localparam logic [op_w-1:0] op_fanfare = 4'h5;  // Move, then play the fanfare.
  localparam logic [op_w-1:0] op_tour    = 4'h6;  // Hand off to the tour logic.

  // Move view: opcode, heading code, square count.
  typedef struct packed {
    logic [op_w-1:0]       opcode;
    logic [hdg_code_w-1:0] hdg_code;
    logic [sq_w-1:0]       squares;
  } mv_cmd_t;

  // Generic view: opcode and whatever follows it.
  typedef struct packed {
    logic [op_w-1:0]       opcode;
    logic [cmd_w-op_w-1:0] payload;
  } gen_cmd_t;

  // Same 16 bits, decoded either way.
  typedef union packed {
    mv_cmd_t  mv;
    gen_cmd_t gen;
  } cmd_word_u;

endpackage
